//--- flist.f
verilog/rv32i_types_pkg.sv
verilog/rv32i_ctrl_pkg.sv
verilog/control.sv
verilog/regfile.sv
verilog/exec_unit.sv
verilog/forwarding_unit.sv
verilog/mem_align.sv
verilog/datapath.sv
tb/tb_memory.sv
tb/tb_datapath.sv

//--- Bender.yml
package:
  name: rv32i_datapath

sources:
  - verilog/rv32i_types_pkg.sv
  - verilog/rv32i_ctrl_pkg.sv
  - verilog/control.sv
  - verilog/regfile.sv
  - verilog/exec_unit.sv
  - verilog/forwarding_unit.sv
  - verilog/mem_align.sv
  - verilog/datapath.sv
  - target: test
    files:
      - tb/tb_memory.sv
      - tb/tb_datapath.sv

//--- tb/tb_datapath.sv
`default_nettype none

module tb_datapath
	import rv32i_types_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic reset;
	logic advance;
	rv32i_word inst;
	rv32i_word mem_rdata;
	rv32i_word inst_addr;
	rv32i_word mem_address;
	rv32i_word mem_wdata;
	logic [3:0] mem_byte_enable;
	logic dread;
	logic dwrite;

	integer seed = 32'h04f69a68;
	bit stall_en;
	bit stall_now;
	int cycles;
	int limit;
	rv32i_word prog [0:255];
	int prog_len;
	rv32i_word exp_addr [0:255];
	rv32i_word exp_data [0:255];
	logic [3:0] exp_be [0:255];
	int exp_count;
	int exp_loads;
	rv32i_word saved_addr [0:255];
	rv32i_word saved_data [0:255];
	logic [3:0] saved_be [0:255];
	int saved_count;
	rv32i_word out_addr;

	datapath dut_i (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.inst(inst),
		.mem_rdata(mem_rdata),
		.inst_addr(inst_addr),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.dread(dread),
		.dwrite(dwrite)
	);

	tb_memory mem_i (
		.clk(clk),
		.advance(advance),
		.inst_addr(inst_addr),
		.inst(inst),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable),
		.dread(dread),
		.dwrite(dwrite),
		.mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// random back-pressure only while a stalled run is active
	always @(posedge clk) begin
		stall_now = stall_en;
		#1;
		advance = stall_now ? (($random(seed) & 3) != 0) : 1'b1;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: program did not reach its final store after %0d cycles", cycles);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	// instruction encoders
	function automatic rv32i_word r_type(input logic [6:0] f7, input rv32i_reg rs2,
		input rv32i_reg rs1, input logic [2:0] f3, input rv32i_reg rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv32i_word i_type(input logic [11:0] imm, input rv32i_reg rs1,
		input logic [2:0] f3, input rv32i_reg rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv32i_word s_type(input logic [11:0] imm, input rv32i_reg rs2,
		input rv32i_reg rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv32i_word b_type(input logic [12:0] imm, input rv32i_reg rs2,
		input rv32i_reg rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv32i_word u_type(input logic [19:0] imm, input rv32i_reg rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rv32i_word j_type(input logic [20:0] imm, input rv32i_reg rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic bit branch_taken(input logic [2:0] f3, input rv32i_word a,
		input rv32i_word b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_word(input string name, input rv32i_word expected,
		input rv32i_word actual);
		if (expected !== actual) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_strobe(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %b actual %b", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "byte enable mismatch");
		end
	endtask

	task automatic begin_program();
		prog_len = 0;
		exp_count = 0;
		exp_loads = 0;
	endtask

	task automatic emit(input rv32i_word word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic expect_store(input rv32i_word addr, input rv32i_word data,
		input logic [3:0] be);
		exp_addr[exp_count] = addr;
		exp_data[exp_count] = data;
		exp_be[exp_count] = be;
		exp_count++;
	endtask

	// always lui then addi
	task automatic load_const(input rv32i_reg rd, input rv32i_word value);
		rv32i_word hi;
		hi = {12'b0, value[31:12]} + value[11];
		emit(u_type(hi[19:0], rd, op_lui));
		emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
	endtask

	task automatic finish_program();
		emit(s_type(12'h3fc, 5'd0, 5'd0, 3'b010));
		emit(j_type(21'd0, 5'd0));
	endtask

	// instr writes x3 and the store puts it in the next output word
	task automatic alu_case(input rv32i_word instr, input rv32i_word expected);
		emit(instr);
		emit(s_type(out_addr[11:0], 5'd3, 5'd0, 3'b010));
		expect_store(out_addr, expected, 4'hf);
		out_addr += 4;
	endtask

	// one unrelated instruction between load and use
	task automatic load_case(input logic [11:0] addr, input logic [2:0] f3,
		input rv32i_word expected);
		emit(i_type(addr, 5'd0, f3, 5'd12, op_load));
		emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, op_imm));
		emit(s_type(out_addr[11:0], 5'd12, 5'd0, 3'b010));
		expect_store(out_addr, expected, 4'hf);
		exp_loads++;
		out_addr += 4;
	endtask

	task automatic run_program(input string name, input bit stall);
		limit += 4 * prog_len;
		@(posedge clk);
		#1;
		reset = 1'b1;
		stall_en = 1'b0;
		@(posedge clk);
		#1;
		mem_i.clear();
		for (int i = 0; i < prog_len; i++) begin
			mem_i.write_inst(i, prog[i]);
		end
		repeat (9) @(posedge clk);
		#1;
		check_word({name, " pc after reset"}, 32'h0000_0000, inst_addr);
		reset = 1'b0;
		stall_en = stall;
		while (!mem_i.done) begin
			@(posedge clk);
			#1;
		end
		stall_en = 1'b0;
		check_word({name, " load count"}, exp_loads, mem_i.read_count);
		if (stall) begin
			check_word({name, " count vs unstalled"}, saved_count, mem_i.log_count);
			for (int i = 0; i < saved_count; i++) begin
				check_word($sformatf("%s vs unstalled %0d address", name, i), saved_addr[i],
					mem_i.log_addr[i]);
				check_word($sformatf("%s vs unstalled %0d data", name, i), saved_data[i],
					mem_i.log_data[i]);
				check_strobe($sformatf("%s vs unstalled %0d strobe", name, i), saved_be[i],
					mem_i.log_be[i]);
			end
		end else begin
			check_word({name, " store count"}, exp_count, mem_i.log_count);
			for (int i = 0; i < exp_count; i++) begin
				check_word($sformatf("%s store %0d address", name, i), exp_addr[i],
					mem_i.log_addr[i]);
				check_word($sformatf("%s store %0d data", name, i), exp_data[i],
					mem_i.log_data[i]);
				check_strobe($sformatf("%s store %0d strobe", name, i), exp_be[i],
					mem_i.log_be[i]);
			end
			saved_count = mem_i.log_count;
			for (int i = 0; i < saved_count; i++) begin
				saved_addr[i] = mem_i.log_addr[i];
				saved_data[i] = mem_i.log_data[i];
				saved_be[i] = mem_i.log_be[i];
			end
		end
	endtask

	task automatic alu_operations();
		rv32i_word a;
		rv32i_word b;
		rv32i_word p;
		a = 32'h8765_4321;
		b = 32'hffff_fff9;
		begin_program();
		out_addr = 32'h100;
		load_const(5'd1, a);
		load_const(5'd2, b);
		alu_case(r_type(7'h00, 2, 1, 3'b000, 3), a + b);
		alu_case(r_type(7'h20, 2, 1, 3'b000, 3), a - b);
		alu_case(r_type(7'h00, 2, 1, 3'b001, 3), a << b[4:0]);
		alu_case(r_type(7'h00, 2, 1, 3'b010, 3), {31'b0, $signed(a) < $signed(b)});
		alu_case(r_type(7'h00, 1, 2, 3'b010, 3), {31'b0, $signed(b) < $signed(a)});
		alu_case(r_type(7'h00, 2, 1, 3'b011, 3), {31'b0, a < b});
		alu_case(r_type(7'h00, 2, 1, 3'b100, 3), a ^ b);
		alu_case(r_type(7'h00, 2, 1, 3'b101, 3), a >> b[4:0]);
		alu_case(r_type(7'h20, 2, 1, 3'b101, 3), $signed(a) >>> b[4:0]);
		alu_case(r_type(7'h00, 2, 1, 3'b110, 3), a | b);
		alu_case(r_type(7'h00, 2, 1, 3'b111, 3), a & b);
		alu_case(i_type(12'hf9c, 1, 3'b000, 3, op_imm), a + 32'hffff_ff9c);
		alu_case(i_type(12'h005, 1, 3'b010, 3, op_imm), {31'b0, $signed(a) < 5});
		alu_case(i_type(12'hfff, 1, 3'b011, 3, op_imm), {31'b0, a < 32'hffff_ffff});
		alu_case(i_type(12'h7ff, 1, 3'b100, 3, op_imm), a ^ 32'h0000_07ff);
		alu_case(i_type(12'hf00, 1, 3'b110, 3, op_imm), a | 32'hffff_ff00);
		alu_case(i_type(12'h0f0, 1, 3'b111, 3, op_imm), a & 32'h0000_00f0);
		alu_case(i_type(12'h004, 1, 3'b001, 3, op_imm), a << 4);
		alu_case(i_type(12'h008, 1, 3'b101, 3, op_imm), a >> 8);
		alu_case(i_type(12'h408, 1, 3'b101, 3, op_imm), $signed(a) >>> 8);
		alu_case(u_type(20'habcde, 3, op_lui), 32'habcd_e000);
		p = prog_len * 4;
		alu_case(u_type(20'h12345, 3, op_auipc), p + 32'h1234_5000);
		finish_program();
		run_program("alu", 1'b0);
	endtask

	task automatic forwarding_chain(input bit stall);
		rv32i_word r5;
		rv32i_word r6;
		rv32i_word r7;
		rv32i_word r8;
		rv32i_word r9;
		rv32i_word r10;
		rv32i_word r13;
		begin_program();
		r5 = 3;
		r6 = r5 + 4;
		r7 = r6 + r5;
		r8 = r7 - r5;
		r9 = r8 + r6;
		r10 = r9 << r7[4:0];
		r13 = 32'h1000 + r5;
		emit(i_type(12'd3, 0, 3'b000, 5, op_imm));
		emit(i_type(12'd4, 5, 3'b000, 6, op_imm));
		emit(r_type(7'h00, 5, 6, 3'b000, 7));
		emit(r_type(7'h20, 5, 7, 3'b000, 8));
		emit(r_type(7'h00, 6, 8, 3'b000, 9));
		emit(r_type(7'h00, 7, 9, 3'b001, 10));
		emit(i_type(12'h200, 0, 3'b000, 11, op_imm));
		emit(s_type(12'h000, 10, 11, 3'b010));
		emit(s_type(12'h004, 9, 11, 3'b010));
		emit(s_type(12'h008, 8, 11, 3'b010));
		// u_imm and compare results forwarded from the memory stage
		emit(u_type(20'h00001, 12, op_lui));
		emit(r_type(7'h00, 5, 12, 3'b000, 13));
		emit(s_type(12'h20c, 13, 0, 3'b010));
		emit(r_type(7'h00, 6, 5, 3'b010, 14));
		emit(s_type(12'h210, 14, 0, 3'b010));
		expect_store(32'h200, r10, 4'hf);
		expect_store(32'h204, r9, 4'hf);
		expect_store(32'h208, r8, 4'hf);
		expect_store(32'h20c, r13, 4'hf);
		expect_store(32'h210, {31'b0, $signed(r5) < $signed(r6)}, 4'hf);
		finish_program();
		run_program(stall ? "forwarding stalled" : "forwarding", stall);
	endtask

	task automatic branch_kinds();
		logic [2:0] kinds [0:5];
		rv32i_word vals [1:2];
		rv32i_reg r1;
		rv32i_reg r2;
		rv32i_word base;
		int n;
		kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		vals[1] = 32'd5;
		vals[2] = 32'hffff_fffd;
		begin_program();
		load_const(5'd1, vals[1]);
		load_const(5'd2, vals[2]);
		load_const(5'd20, 32'h5a5);
		n = 0;
		for (int k = 0; k < 6; k++) begin
			for (int p = 0; p < 3; p++) begin
				r1 = (p == 1) ? 5'd2 : 5'd1;
				r2 = (p == 0) ? 5'd2 : 5'd1;
				base = 32'h100 + 12 * n;
				// markers in both slots and the landing store at +12
				emit(b_type(13'd12, r2, r1, kinds[k]));
				emit(s_type(base[11:0], 20, 0, 3'b010));
				emit(s_type(base[11:0] + 12'd4, 20, 0, 3'b010));
				emit(s_type(base[11:0] + 12'd8, 20, 0, 3'b010));
				if (!branch_taken(kinds[k], vals[r1], vals[r2])) begin
					expect_store(base, 32'h5a5, 4'hf);
					expect_store(base + 4, 32'h5a5, 4'hf);
				end
				expect_store(base + 8, 32'h5a5, 4'hf);
				n++;
			end
		end
		finish_program();
		run_program("branches", 1'b0);
	endtask

	task automatic jump_links();
		rv32i_word p;
		rv32i_word target;
		begin_program();
		load_const(5'd20, 32'h5a5);
		p = prog_len * 4;
		emit(j_type(21'd12, 1));
		emit(s_type(12'h100, 20, 0, 3'b010));
		emit(s_type(12'h104, 20, 0, 3'b010));
		emit(s_type(12'h108, 1, 0, 3'b010));
		expect_store(32'h108, p + 4, 4'hf);
		// jalr target with bit 0 set, which the jump clears
		p = prog_len * 4 + 8;
		target = p + 12;
		load_const(5'd5, target + 1);
		emit(i_type(12'd0, 5, 3'b000, 6, op_jalr));
		emit(s_type(12'h10c, 20, 0, 3'b010));
		emit(s_type(12'h110, 20, 0, 3'b010));
		emit(s_type(12'h114, 6, 0, 3'b010));
		expect_store(32'h114, p + 4, 4'hf);
		finish_program();
		run_program("jumps", 1'b0);
	endtask

	task automatic access_widths(input bit stall);
		rv32i_word v;
		rv32i_word lane;
		v = 32'h8899_aabb;
		begin_program();
		load_const(5'd10, v);
		emit(s_type(12'h300, 10, 0, 3'b010));
		expect_store(32'h300, v, 4'b1111);
		for (int k = 0; k < 4; k++) begin
			emit(s_type(12'h310 + k, 10, 0, 3'b000));
			expect_store(32'h310 + k, (v & 32'hff) << (8 * k), 4'b0001 << k);
		end
		for (int k = 0; k < 4; k += 2) begin
			emit(s_type(12'h320 + k, 10, 0, 3'b001));
			expect_store(32'h320 + k, (v & 32'hffff) << (8 * k), 4'b0011 << k);
		end
		out_addr = 32'h380;
		for (int k = 0; k < 4; k++) begin
			lane = v >> (8 * k);
			load_case(12'h300 + k, 3'b000, {{24{lane[7]}}, lane[7:0]});
			load_case(12'h300 + k, 3'b100, {24'b0, lane[7:0]});
		end
		for (int k = 0; k < 4; k += 2) begin
			lane = v >> (8 * k);
			load_case(12'h300 + k, 3'b001, {{16{lane[15]}}, lane[15:0]});
			load_case(12'h300 + k, 3'b101, {16'b0, lane[15:0]});
		end
		load_case(12'h300, 3'b010, v);
		load_case(12'h310, 3'b010, {4{v[7:0]}});
		load_case(12'h320, 3'b010, {2{v[15:0]}});
		finish_program();
		run_program(stall ? "memory stalled" : "memory", stall);
	endtask

	initial begin
		reset = 1'b1;
		advance = 1'b1;
		stall_en = 1'b0;
		cycles = 0;
		limit = 200;
		saved_count = 0;
		alu_operations();
		branch_kinds();
		jump_links();
		forwarding_chain(1'b0);
		forwarding_chain(1'b1);
		access_widths(1'b0);
		access_widths(1'b1);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_memory.sv
`default_nettype none

module tb_memory
	import rv32i_types_pkg::*;
(
	input logic clk,
	input logic advance,
	input rv32i_word inst_addr,
	output rv32i_word inst,
	input rv32i_word mem_address,
	input rv32i_word mem_wdata,
	input logic [3:0] mem_byte_enable,
	input logic dread,
	input logic dwrite,
	output rv32i_word mem_rdata
);
	timeunit 1ns;
	timeprecision 100ps;

	// a store here ends the program and is not logged
	localparam rv32i_word end_address = 32'h0000_03fc;

	rv32i_word imem [0:255];
	rv32i_word dmem [0:255];
	rv32i_word log_addr [0:255];
	rv32i_word log_data [0:255];
	logic [3:0] log_be [0:255];
	int log_count;
	int read_count;
	logic done;
	rv32i_word lane_mask;

	assign inst = imem[inst_addr[9:2]];
	assign mem_rdata = dread ? dmem[mem_address[9:2]] : '0;
	assign lane_mask = {{8{mem_byte_enable[3]}}, {8{mem_byte_enable[2]}},
		{8{mem_byte_enable[1]}}, {8{mem_byte_enable[0]}}};

	task automatic clear();
		rv32i_word a;
		for (int i = 0; i < 256; i++) begin
			a = i * 4;
			// addi x0, x0, <address>
			imem[i] = {a[11:0], 20'h00013};
			dmem[i] = {a[15:0] ^ 16'h5a5a, a[15:0]};
		end
		log_count = 0;
		read_count = 0;
		done = 1'b0;
	endtask

	task automatic write_inst(input int index, input rv32i_word word);
		imem[index] = word;
	endtask

	always @(posedge clk) begin
		// one advancing cycle per load leaving the memory stage
		if (dread && advance) begin
			read_count = read_count + 1;
		end
		if (dwrite && advance) begin
			dmem[mem_address[9:2]] = (dmem[mem_address[9:2]] & ~lane_mask) |
				(mem_wdata & lane_mask);
			if (mem_address == end_address) begin
				done = 1'b1;
			end else begin
				log_addr[log_count] = mem_address;
				log_data[log_count] = mem_wdata & lane_mask;
				log_be[log_count] = mem_byte_enable;
				log_count = log_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`default_nettype none

module datapath
	import rv32i_types_pkg::*;
	import rv32i_ctrl_pkg::*;
#(
	parameter rv32i_word reset_pc = 32'h0000_0000
)
(
	input logic clk,
	input logic reset,
	input logic advance,
	input rv32i_word inst,
	input rv32i_word mem_rdata,
	output rv32i_word inst_addr,
	output rv32i_word mem_address,
	output rv32i_word mem_wdata,
	output logic [3:0] mem_byte_enable,
	output logic dread,
	output logic dwrite
);

	// fetch
	rv32i_word pc;
	rv32i_word pc_next;

	// decode
	rv32i_word ifid_pc;
	rv32i_word ifid_inst;
	logic ifid_valid;
	control_word_t id_cw;
	logic id_flush;
	rv32i_word id_rs1_raw;
	rv32i_word id_rs2_raw;
	rv32i_word id_rs1;
	rv32i_word id_rs2;
	logic id_fwd_a;
	logic id_fwd_b;

	// execute
	rv32i_word idex_pc;
	rv32i_word idex_rs1;
	rv32i_word idex_rs2;
	control_word_t idex_cw;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	rv32i_word ex_rs1;
	rv32i_word ex_rs2;
	rv32i_word alu_a;
	rv32i_word alu_b;
	rv32i_word cmp_b;
	rv32i_word alu_out;
	logic br_en;
	logic ex_redirect;

	// memory
	rv32i_word exmem_pc;
	rv32i_word exmem_alu;
	rv32i_word exmem_rs2;
	logic exmem_br_en;
	control_word_t exmem_cw;
	rv32i_word exmem_result;
	rv32i_word load_data;

	// write back
	rv32i_word memwb_pc;
	rv32i_word memwb_alu;
	logic memwb_br_en;
	rv32i_word memwb_load;
	control_word_t memwb_cw;
	rv32i_word wb_value;

	function automatic rv32i_word stage_result(
		input regfilemux_sel_t sel,
		input rv32i_word alu,
		input logic br,
		input rv32i_word imm,
		input rv32i_word pc_val
	);
		case (sel)
			rf_br_en: return {31'b0, br};
			rf_u_imm: return imm;
			rf_pc_plus4: return pc_val + 32'd4;
			default: return alu;
		endcase
	endfunction

	assign inst_addr = pc;

	// branch or jump resolved in execute
	assign ex_redirect = ~idex_cw.flush && (
		((idex_cw.opcode == op_br) && br_en) ||
		(idex_cw.opcode == op_jal) ||
		(idex_cw.opcode == op_jalr));

	always_comb begin
		if (ex_redirect && (idex_cw.opcode == op_jalr)) begin
			pc_next = {alu_out[31:1], 1'b0};
		end else if (ex_redirect) begin
			pc_next = alu_out;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	assign id_flush = ex_redirect || ~ifid_valid;

	control control_i (
		.inst(ifid_inst),
		.flush(id_flush),
		.cw(id_cw)
	);

	regfile regfile_i (
		.clk(clk),
		.reset(reset),
		.load(memwb_cw.load_regfile && advance),
		.in(wb_value),
		.src_a(id_cw.src1),
		.src_b(id_cw.src2),
		.dest(memwb_cw.dest),
		.reg_a(id_rs1_raw),
		.reg_b(id_rs2_raw)
	);

	assign id_rs1 = id_fwd_a ? wb_value : id_rs1_raw;
	assign id_rs2 = id_fwd_b ? wb_value : id_rs2_raw;

	forwarding_unit forwarding_unit_i (
		.ex_src1(idex_cw.src1),
		.ex_src2(idex_cw.src2),
		.id_src1(id_cw.src1),
		.id_src2(id_cw.src2),
		.exmem_dest(exmem_cw.dest),
		.memwb_dest(memwb_cw.dest),
		.ex_rs1_valid(idex_cw.rs1_valid),
		.ex_rs2_valid(idex_cw.rs2_valid),
		.id_rs1_valid(id_cw.rs1_valid),
		.id_rs2_valid(id_cw.rs2_valid),
		.exmem_write(exmem_cw.load_regfile),
		.memwb_write(memwb_cw.load_regfile),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.id_fwd_a(id_fwd_a),
		.id_fwd_b(id_fwd_b)
	);

	// operand muxes in execute
	always_comb begin
		case (fwd_a)
			fwd_exmem: ex_rs1 = exmem_result;
			fwd_memwb: ex_rs1 = wb_value;
			default: ex_rs1 = idex_rs1;
		endcase
		case (fwd_b)
			fwd_exmem: ex_rs2 = exmem_result;
			fwd_memwb: ex_rs2 = wb_value;
			default: ex_rs2 = idex_rs2;
		endcase
		alu_a = (idex_cw.alumux1_sel == alumux1_pc) ? idex_pc : ex_rs1;
		alu_b = (idex_cw.alumux2_sel == alumux2_rs2) ? ex_rs2 : idex_cw.imm;
		cmp_b = (idex_cw.cmpmux_sel == cmpmux_i_imm) ? idex_cw.imm : ex_rs2;
	end

	exec_unit exec_unit_i (
		.aluop(idex_cw.aluop),
		.cmpop(idex_cw.cmpop),
		.a(alu_a),
		.b(alu_b),
		.cmp_a(ex_rs1),
		.cmp_b(cmp_b),
		.f(alu_out),
		.br_en(br_en)
	);

	// memory stage
	assign mem_address = exmem_alu;
	assign dread = exmem_cw.mem_read;
	assign dwrite = exmem_cw.mem_write;
	assign exmem_result = stage_result(exmem_cw.regfilemux_sel, exmem_alu, exmem_br_en,
		exmem_cw.imm, exmem_pc);

	mem_align mem_align_i (
		.funct3(exmem_cw.funct3),
		.addr_low(exmem_alu[1:0]),
		.store_data(exmem_rs2),
		.rdata(mem_rdata),
		.wdata(mem_wdata),
		.load_data(load_data),
		.byte_enable(mem_byte_enable)
	);

	// write back
	assign wb_value = (memwb_cw.regfilemux_sel == rf_load) ? memwb_load :
		stage_result(memwb_cw.regfilemux_sel, memwb_alu, memwb_br_en, memwb_cw.imm, memwb_pc);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			ifid_valid <= 1'b0;
			idex_cw <= cw_bubble;
			exmem_cw <= cw_bubble;
			memwb_cw <= cw_bubble;
		end else if (advance) begin
			pc <= pc_next;
			// instruction fetched behind a redirect is dropped
			ifid_valid <= ~ex_redirect;
			idex_cw <= id_cw;
			exmem_cw <= idex_cw;
			memwb_cw <= exmem_cw;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ifid_pc <= pc;
			ifid_inst <= inst;
			idex_pc <= ifid_pc;
			idex_rs1 <= id_rs1;
			idex_rs2 <= id_rs2;
			exmem_pc <= idex_pc;
			exmem_alu <= alu_out;
			exmem_rs2 <= ex_rs2;
			exmem_br_en <= br_en;
			memwb_pc <= exmem_pc;
			memwb_alu <= exmem_alu;
			memwb_br_en <= exmem_br_en;
			memwb_load <= load_data;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mem_align.sv
`default_nettype none

module mem_align
	import rv32i_types_pkg::*;
(
	input logic [2:0] funct3,
	input logic [1:0] addr_low,
	input rv32i_word store_data,
	input rv32i_word rdata,
	output rv32i_word wdata,
	output rv32i_word load_data,
	output logic [3:0] byte_enable
);

	logic [7:0] byte_lane;
	logic [15:0] half_lane;

	// store side
	always_comb begin
		case (store_funct3_t'(funct3))
			sb: begin
				wdata = {4{store_data[7:0]}};
				byte_enable = 4'b0001 << addr_low;
			end
			sh: begin
				wdata = {2{store_data[15:0]}};
				byte_enable = 4'b0011 << {addr_low[1], 1'b0};
			end
			default: begin
				wdata = store_data;
				byte_enable = 4'b1111;
			end
		endcase
	end

	// load side, halfwords use the aligned half only
	assign byte_lane = rdata[{addr_low, 3'b000} +: 8];
	assign half_lane = addr_low[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		case (load_funct3_t'(funct3))
			lb: load_data = {{24{byte_lane[7]}}, byte_lane};
			lbu: load_data = {24'b0, byte_lane};
			lh: load_data = {{16{half_lane[15]}}, half_lane};
			lhu: load_data = {16'b0, half_lane};
			default: load_data = rdata;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/forwarding_unit.sv
`default_nettype none

module forwarding_unit
	import rv32i_types_pkg::*;
	import rv32i_ctrl_pkg::*;
(
	input rv32i_reg ex_src1,
	input rv32i_reg ex_src2,
	input rv32i_reg id_src1,
	input rv32i_reg id_src2,
	input rv32i_reg exmem_dest,
	input rv32i_reg memwb_dest,
	input logic ex_rs1_valid,
	input logic ex_rs2_valid,
	input logic id_rs1_valid,
	input logic id_rs2_valid,
	input logic exmem_write,
	input logic memwb_write,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output logic id_fwd_a,
	output logic id_fwd_b
);

	function automatic logic hit(
		input rv32i_reg src,
		input logic src_valid,
		input rv32i_reg dest,
		input logic write
	);
		return src_valid && write && (src != 5'd0) && (src == dest);
	endfunction

	// younger result wins
	always_comb begin
		if (hit(ex_src1, ex_rs1_valid, exmem_dest, exmem_write)) begin
			fwd_a = fwd_exmem;
		end else if (hit(ex_src1, ex_rs1_valid, memwb_dest, memwb_write)) begin
			fwd_a = fwd_memwb;
		end else begin
			fwd_a = fwd_none;
		end

		if (hit(ex_src2, ex_rs2_valid, exmem_dest, exmem_write)) begin
			fwd_b = fwd_exmem;
		end else if (hit(ex_src2, ex_rs2_valid, memwb_dest, memwb_write)) begin
			fwd_b = fwd_memwb;
		end else begin
			fwd_b = fwd_none;
		end
	end

	assign id_fwd_a = hit(id_src1, id_rs1_valid, memwb_dest, memwb_write);
	assign id_fwd_b = hit(id_src2, id_rs2_valid, memwb_dest, memwb_write);

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`default_nettype none

module exec_unit
	import rv32i_types_pkg::*;
	import rv32i_ctrl_pkg::*;
(
	input alu_op_t aluop,
	input cmp_op_t cmpop,
	input rv32i_word a,
	input rv32i_word b,
	input rv32i_word cmp_a,
	input rv32i_word cmp_b,
	output rv32i_word f,
	output logic br_en
);

	always_comb begin
		unique case (aluop)
			alu_sub: f = a - b;
			alu_sll: f = a << b[4:0];
			alu_slt: f = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: f = {31'b0, a < b};
			alu_xor: f = a ^ b;
			alu_srl: f = a >> b[4:0];
			alu_sra: f = $signed(a) >>> b[4:0];
			alu_or: f = a | b;
			alu_and: f = a & b;
			alu_pass_b: f = b;
			default: f = a + b;
		endcase
	end

	always_comb begin
		unique case (cmpop)
			cmp_eq: br_en = (cmp_a == cmp_b);
			cmp_ne: br_en = (cmp_a != cmp_b);
			cmp_lt: br_en = ($signed(cmp_a) < $signed(cmp_b));
			cmp_ge: br_en = ($signed(cmp_a) >= $signed(cmp_b));
			cmp_ltu: br_en = (cmp_a < cmp_b);
			cmp_geu: br_en = (cmp_a >= cmp_b);
			default: br_en = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none

module regfile
	import rv32i_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input rv32i_word in,
	input rv32i_reg src_a,
	input rv32i_reg src_b,
	input rv32i_reg dest,
	output rv32i_word reg_a,
	output rv32i_word reg_b
);

	// x0 has no storage
	rv32i_word regs [31:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (load && (dest != 5'd0)) begin
			regs[dest] <= in;
		end
	end

	// same-cycle write is visible to the read
	assign reg_a = (src_a == 5'd0) ? '0 :
		(load && (src_a == dest)) ? in : regs[src_a];
	assign reg_b = (src_b == 5'd0) ? '0 :
		(load && (src_b == dest)) ? in : regs[src_b];

endmodule

`default_nettype wire

//--- verilog/control.sv
`default_nettype none

module control
	import rv32i_types_pkg::*;
	import rv32i_ctrl_pkg::*;
(
	input rv32i_word inst,
	input logic flush,
	output control_word_t cw
);

	rv32i_word i_imm;
	rv32i_word s_imm;
	rv32i_word b_imm;
	rv32i_word u_imm;
	rv32i_word j_imm;
	logic is_reg;

	assign i_imm = {{21{inst[31]}}, inst[30:20]};
	assign s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
	assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign u_imm = {inst[31:12], 12'h000};
	assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign is_reg = (inst[6:0] == op_reg);

	always_comb begin
		cw = cw_bubble;
		cw.opcode = rv32i_opcode_t'(inst[6:0]);
		cw.funct3 = inst[14:12];
		cw.src1 = inst[19:15];
		cw.src2 = inst[24:20];
		cw.dest = inst[11:7];
		cw.flush = 1'b0;
		cw.aluop = alu_add;
		cw.cmpop = cmp_op_t'(inst[14:12]);
		cw.alumux1_sel = alumux1_rs1;
		cw.alumux2_sel = alumux2_i_imm;
		cw.cmpmux_sel = cmpmux_rs2;
		cw.regfilemux_sel = rf_alu_out;

		unique case (cw.opcode)
			op_lui: begin
				cw.rd_valid = 1'b1;
				cw.aluop = alu_pass_b;
				cw.alumux2_sel = alumux2_u_imm;
				cw.regfilemux_sel = rf_u_imm;
			end
			op_auipc: begin
				cw.rd_valid = 1'b1;
				cw.alumux1_sel = alumux1_pc;
				cw.alumux2_sel = alumux2_u_imm;
			end
			op_jal: begin
				cw.rd_valid = 1'b1;
				cw.alumux1_sel = alumux1_pc;
				cw.alumux2_sel = alumux2_j_imm;
				cw.regfilemux_sel = rf_pc_plus4;
			end
			op_jalr: begin
				cw.rs1_valid = 1'b1;
				cw.rd_valid = 1'b1;
				cw.regfilemux_sel = rf_pc_plus4;
			end
			op_br: begin
				cw.rs1_valid = 1'b1;
				cw.rs2_valid = 1'b1;
				cw.alumux1_sel = alumux1_pc;
				cw.alumux2_sel = alumux2_b_imm;
			end
			op_load: begin
				cw.rs1_valid = 1'b1;
				cw.rd_valid = 1'b1;
				cw.mem_read = 1'b1;
				cw.regfilemux_sel = rf_load;
			end
			op_store: begin
				cw.rs1_valid = 1'b1;
				cw.rs2_valid = 1'b1;
				cw.mem_write = 1'b1;
				cw.alumux2_sel = alumux2_s_imm;
			end
			op_imm, op_reg: begin
				cw.rs1_valid = 1'b1;
				cw.rs2_valid = is_reg;
				cw.rd_valid = 1'b1;
				cw.alumux2_sel = is_reg ? alumux2_rs2 : alumux2_i_imm;
				cw.cmpmux_sel = is_reg ? cmpmux_rs2 : cmpmux_i_imm;
				unique case (inst[14:12])
					3'b000: cw.aluop = (is_reg && inst[30]) ? alu_sub : alu_add;
					3'b001: cw.aluop = alu_sll;
					3'b010: begin
						// set-less-than goes through the comparator
						cw.aluop = alu_slt;
						cw.cmpop = cmp_lt;
						cw.regfilemux_sel = rf_br_en;
					end
					3'b011: begin
						cw.aluop = alu_sltu;
						cw.cmpop = cmp_ltu;
						cw.regfilemux_sel = rf_br_en;
					end
					3'b100: cw.aluop = alu_xor;
					3'b101: cw.aluop = inst[30] ? alu_sra : alu_srl;
					3'b110: cw.aluop = alu_or;
					default: cw.aluop = alu_and;
				endcase
			end
			// unsupported opcode becomes a bubble
			default: cw.flush = 1'b1;
		endcase

		unique case (cw.alumux2_sel)
			alumux2_u_imm: cw.imm = u_imm;
			alumux2_b_imm: cw.imm = b_imm;
			alumux2_s_imm: cw.imm = s_imm;
			alumux2_j_imm: cw.imm = j_imm;
			default: cw.imm = i_imm;
		endcase

		cw.load_regfile = cw.rd_valid && (cw.dest != 5'd0);

		if (flush) begin
			cw = cw_bubble;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rv32i_ctrl_pkg.sv
`default_nettype none

package rv32i_ctrl_pkg;

	import rv32i_types_pkg::*;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	// encoded like the branch funct3 field
	typedef enum logic [2:0] {
		cmp_eq = 3'b000,
		cmp_ne = 3'b001,
		cmp_lt = 3'b100,
		cmp_ge = 3'b101,
		cmp_ltu = 3'b110,
		cmp_geu = 3'b111
	} cmp_op_t;

	typedef enum logic {
		alumux1_rs1,
		alumux1_pc
	} alumux1_sel_t;

	typedef enum logic [2:0] {
		alumux2_i_imm,
		alumux2_u_imm,
		alumux2_b_imm,
		alumux2_s_imm,
		alumux2_j_imm,
		alumux2_rs2
	} alumux2_sel_t;

	typedef enum logic {
		cmpmux_rs2,
		cmpmux_i_imm
	} cmpmux_sel_t;

	typedef enum logic [2:0] {
		rf_alu_out,
		rf_br_en,
		rf_u_imm,
		rf_load,
		rf_pc_plus4
	} regfilemux_sel_t;

	typedef enum logic [1:0] {
		fwd_none,
		fwd_exmem,
		fwd_memwb
	} fwd_sel_t;

	typedef struct packed {
		rv32i_opcode_t opcode;
		logic [2:0] funct3;
		rv32i_reg src1;
		rv32i_reg src2;
		rv32i_reg dest;
		logic rs1_valid;
		logic rs2_valid;
		logic rd_valid;
		logic load_regfile;
		logic mem_read;
		logic mem_write;
		alu_op_t aluop;
		cmp_op_t cmpop;
		alumux1_sel_t alumux1_sel;
		alumux2_sel_t alumux2_sel;
		cmpmux_sel_t cmpmux_sel;
		regfilemux_sel_t regfilemux_sel;
		rv32i_word imm;
		logic flush;
	} control_word_t;

	// everything zero except flush, which sits in the lsb
	localparam control_word_t cw_bubble =
		control_word_t'({{($bits(control_word_t) - 1){1'b0}}, 1'b1});

endpackage

`default_nettype wire

//--- verilog/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

	typedef logic [31:0] rv32i_word;
	typedef logic [4:0] rv32i_reg;

	// major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		op_lui = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal = 7'b1101111,
		op_jalr = 7'b1100111,
		op_br = 7'b1100011,
		op_load = 7'b0000011,
		op_store = 7'b0100011,
		op_imm = 7'b0010011,
		op_reg = 7'b0110011
	} rv32i_opcode_t;

	typedef enum logic [2:0] {
		beq = 3'b000,
		bne = 3'b001,
		blt = 3'b100,
		bge = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		lb = 3'b000,
		lh = 3'b001,
		lw = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

endpackage

`default_nettype wire
